/* src/icache_defs.svh */
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// byte address width of the fetch port
`define ICACHE_ADDR_W 32

// word select within a four-word line
`define ICACHE_OFFSET_W 2

// set select with sixteen sets by default
`define ICACHE_INDEX_W 4

// the low 2 bits select a byte within a word and are never stored
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W - 2)

// width of one instruction word
`define ICACHE_WORD_W 32

`endif

/* src/icache_pkg.sv */
package icache_pkg;

    ////////////////////////////////////////
    // controller states
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_miss_req,
        st_refill,
        st_replace,
        st_invalidate
    } ctrl_state_e;

    ////////////////////////////////////////
    // request opcodes
    ////////////////////////////////////////
    typedef enum logic {
        op_fetch,
        op_inval_all
    } cache_op_e;

endpackage

/* src/icache_array_if.sv */
`include "icache_defs.svh"

interface icache_array_if;

    // controller requests
    logic                      lookup_valid;
    logic                      touch;
    logic                      inval_all;

    // storage results
    logic                      hit;
    logic                      hit_way;
    logic                      victim_way;
    logic [`ICACHE_WORD_W-1:0] rdata;

    modport ctrl (
        output lookup_valid,
        output touch,
        output inval_all,
        input  hit,
        input  hit_way,
        input  victim_way,
        input  rdata
    );

    modport storage (
        input  lookup_valid,
        input  touch,
        input  inval_all,
        output hit,
        output hit_way,
        output victim_way,
        output rdata
    );

endinterface

/* src/icache_req_buffer.sv */
`include "icache_defs.svh"

module icache_req_buffer (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        req_valid,
    input  icache_pkg::cache_op_e       req_op,
    input  logic [`ICACHE_ADDR_W-1:0]   req_addr,
    input  logic                        capture,
    output icache_pkg::cache_op_e       held_op,
    output logic [`ICACHE_INDEX_W-1:0]  held_index,
    output logic [`ICACHE_TAG_W-1:0]    held_tag,
    output logic [`ICACHE_OFFSET_W-1:0] held_offset
);
    import icache_pkg::*;

    localparam int OFS_LO = 2;
    localparam int IDX_LO = OFS_LO + `ICACHE_OFFSET_W;
    localparam int TAG_LO = IDX_LO + `ICACHE_INDEX_W;

    // address split into tag, set and word with the byte bits dropped
    always_ff @(posedge clk) begin
        if (capture) begin
            held_op     <= req_op;
            held_offset <= req_addr[IDX_LO-1:OFS_LO];
            held_index  <= req_addr[TAG_LO-1:IDX_LO];
            held_tag    <= req_addr[`ICACHE_ADDR_W-1:TAG_LO];
        end
    end

    // the controller only loads on an accepted request
    a_capture_valid: assert property (
        @(posedge clk) disable iff (!rstn) capture |-> req_valid
    );

endmodule

/* src/icache_storage.sv */
`include "icache_defs.svh"

module icache_storage (
    input  logic                        clk,
    input  logic                        rstn,
    icache_array_if.storage             arr,
    input  logic [`ICACHE_INDEX_W-1:0]  held_index,
    input  logic [`ICACHE_TAG_W-1:0]    held_tag,
    input  logic [`ICACHE_OFFSET_W-1:0] held_offset,
    input  logic                        refill_start,
    input  logic                        fill_we,
    input  logic [`ICACHE_OFFSET_W-1:0] fill_word,
    input  logic [`ICACHE_WORD_W-1:0]   fill_data
);

    localparam int SETS  = 1 << `ICACHE_INDEX_W;
    localparam int WORDS = 1 << `ICACHE_OFFSET_W;

    ////////////////////////////////////////
    // arrays
    ////////////////////////////////////////
    logic [`ICACHE_TAG_W-1:0]  tag_ram  [2][SETS];
    logic [`ICACHE_WORD_W-1:0] data_ram [2][SETS][WORDS];
    logic [SETS-1:0]           valid_q  [2];
    // way used most recently, per set
    logic [SETS-1:0]           mru_q;

    logic [1:0] way_hit;
    logic       fill_way;
    logic       fill_last;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][held_index] && (tag_ram[w][held_index] == held_tag);
        end
    end

    assign arr.hit     = arr.lookup_valid && (|way_hit);
    assign arr.hit_way = way_hit[1];
    assign arr.rdata   = data_ram[arr.hit_way][held_index][held_offset];

    // empty way first, otherwise the older one
    always_comb begin
        if (!valid_q[0][held_index]) begin
            arr.victim_way = 1'b0;
        end else if (!valid_q[1][held_index]) begin
            arr.victim_way = 1'b1;
        end else begin
            arr.victim_way = ~mru_q[held_index];
        end
    end

    ////////////////////////////////////////
    // refill
    ////////////////////////////////////////
    assign fill_last = fill_we && (fill_word == `ICACHE_OFFSET_W'(WORDS - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fill_way <= 1'b0;
        end else if (refill_start) begin
            fill_way <= arr.victim_way;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            data_ram[fill_way][held_index][fill_word] <= fill_data;
        end
        if (fill_last) begin
            tag_ram[fill_way][held_index] <= held_tag;
        end
    end

    // valid bits and recency
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            mru_q      <= '0;
        end else if (arr.inval_all) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
        end else if (fill_last) begin
            valid_q[fill_way][held_index] <= 1'b1;
            mru_q[held_index]             <= fill_way;
        end else if (arr.touch) begin
            mru_q[held_index] <= arr.hit_way;
        end
    end

    // a line is only refilled after a miss, so no tag sits in both ways
    a_single_hit: assert property (
        @(posedge clk) disable iff (!rstn) !(way_hit[0] && way_hit[1])
    );

endmodule

/* src/icache_ctrl.sv */
module icache_ctrl (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  icache_pkg::cache_op_e held_op,
    output logic                  capture,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    icache_array_if.ctrl          arr,
    output logic                  refill_start,
    input  logic                  refill_done
);
    import icache_pkg::*;

    ctrl_state_e state;
    ctrl_state_e next_state;
    logic        fetch_held;
    // way picked for the running refill
    logic        fill_way;

    assign fetch_held = (held_op == op_fetch);

    ////////////////////////////////////////
    // state register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (req_valid) begin
                    next_state = st_lookup;
                end
            end
            st_lookup: begin
                if (!fetch_held) begin
                    next_state = st_invalidate;
                end else if (!arr.hit) begin
                    next_state = st_miss_req;
                end else if (resp_ready && !req_valid) begin
                    next_state = st_idle;
                end
            end
            // mem port takes over from here
            st_miss_req: next_state = st_refill;
            st_refill: begin
                if (refill_done) begin
                    next_state = st_replace;
                end
            end
            // new line is in place so look again
            st_replace: next_state = st_lookup;
            st_invalidate: begin
                if (req_valid) begin
                    next_state = st_lookup;
                end else begin
                    next_state = st_idle;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    ////////////////////////////////////////
    // outputs
    ////////////////////////////////////////
    assign arr.lookup_valid = (state == st_lookup) && fetch_held;
    assign resp_valid       = arr.lookup_valid && arr.hit;

    always_comb begin
        req_ready     = 1'b0;
        capture       = 1'b0;
        refill_start  = 1'b0;
        arr.touch     = 1'b0;
        arr.inval_all = 1'b0;
        case (state)
            st_idle: begin
                req_ready = 1'b1;
                capture   = req_valid;
            end
            st_lookup: begin
                if (next_state == st_miss_req) begin
                    refill_start = 1'b1;
                end else if (resp_valid && resp_ready) begin
                    // completion edge doubles as the next accept
                    req_ready = 1'b1;
                    capture   = req_valid;
                    arr.touch = 1'b1;
                end
            end
            st_invalidate: begin
                arr.inval_all = 1'b1;
                req_ready     = 1'b1;
                capture       = req_valid;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fill_way <= 1'b0;
        end else if (refill_start) begin
            fill_way <= arr.victim_way;
        end
    end

    a_resp_hold: assert property (
        @(posedge clk) disable iff (!rstn) resp_valid && !resp_ready |=> resp_valid
    );

    // the repeated lookup finds the line in the way chosen at miss time
    a_refill_hits: assert property (
        @(posedge clk) disable iff (!rstn)
        state == st_replace |=> arr.hit && (arr.hit_way == fill_way)
    );

endmodule

/* src/icache_mem_port.sv */
`include "icache_defs.svh"

module icache_mem_port (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        refill_start,
    input  logic [`ICACHE_ADDR_W-1:0]   line_addr,
    output logic                        mem_req,
    output logic [`ICACHE_ADDR_W-1:0]   mem_addr,
    input  logic                        mem_addr_ok,
    input  logic                        mem_data_ok,
    input  logic [`ICACHE_WORD_W-1:0]   mem_rdata,
    output logic                        fill_we,
    output logic [`ICACHE_OFFSET_W-1:0] fill_word,
    output logic [`ICACHE_WORD_W-1:0]   fill_data,
    output logic                        refill_done
);

    typedef enum logic [1:0] {
        mp_idle,
        mp_addr,
        mp_data
    } mp_state_e;

    mp_state_e                   state;
    logic [`ICACHE_OFFSET_W-1:0] beat;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= mp_idle;
            beat  <= '0;
        end else begin
            case (state)
                mp_idle: begin
                    if (refill_start) begin
                        state <= mp_addr;
                    end
                end
                mp_addr: begin
                    if (mem_addr_ok) begin
                        state <= mp_data;
                        beat  <= '0;
                    end
                end
                mp_data: begin
                    if (mem_data_ok) begin
                        beat <= beat + 1'b1;
                        if (refill_done) begin
                            state <= mp_idle;
                        end
                    end
                end
                default: state <= mp_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (refill_start) begin
            mem_addr <= line_addr;
        end
    end

    assign mem_req     = (state == mp_addr);
    assign fill_we     = (state == mp_data) && mem_data_ok;
    assign fill_word   = beat;
    assign fill_data   = mem_rdata;
    assign refill_done = fill_we && (&beat);

    a_data_after_addr: assert property (
        @(posedge clk) disable iff (!rstn) mem_data_ok |-> state == mp_data
    );

endmodule

/* src/icache_top.sv */
`include "icache_defs.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rstn,
    // request side
    input  logic                      req_valid,
    output logic                      req_ready,
    input  icache_pkg::cache_op_e     req_op,
    input  logic [`ICACHE_ADDR_W-1:0] req_addr,
    // response side
    output logic                      resp_valid,
    input  logic                      resp_ready,
    output logic [`ICACHE_WORD_W-1:0] resp_data,
    // memory side
    output logic                      mem_req,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr,
    input  logic                      mem_addr_ok,
    input  logic                      mem_data_ok,
    input  logic [`ICACHE_WORD_W-1:0] mem_rdata
);
    import icache_pkg::*;

    cache_op_e                   held_op;
    logic [`ICACHE_INDEX_W-1:0]  held_index;
    logic [`ICACHE_TAG_W-1:0]    held_tag;
    logic [`ICACHE_OFFSET_W-1:0] held_offset;
    logic                        capture;
    logic                        refill_start;
    logic                        refill_done;
    logic                        fill_we;
    logic [`ICACHE_OFFSET_W-1:0] fill_word;
    logic [`ICACHE_WORD_W-1:0]   fill_data;
    logic [`ICACHE_ADDR_W-1:0]   line_addr;

    icache_array_if arr_if ();

    // line aligned with word and byte bits zero
    assign line_addr = {held_tag, held_index, (`ICACHE_OFFSET_W + 2)'(0)};
    assign resp_data = arr_if.rdata;

    icache_req_buffer req_buf0 (
        .clk, .rstn, .req_valid, .req_op, .req_addr, .capture,
        .held_op, .held_index, .held_tag, .held_offset
    );

    icache_ctrl ctrl0 (
        .clk, .rstn, .req_valid, .req_ready, .held_op, .capture,
        .resp_valid, .resp_ready, .arr(arr_if.ctrl), .refill_start, .refill_done
    );

    icache_storage storage0 (
        .clk, .rstn, .arr(arr_if.storage), .held_index, .held_tag, .held_offset,
        .refill_start, .fill_we, .fill_word, .fill_data
    );

    icache_mem_port mem_port0 (
        .clk, .rstn, .refill_start, .line_addr, .mem_req, .mem_addr,
        .mem_addr_ok, .mem_data_ok, .mem_rdata,
        .fill_we, .fill_word, .fill_data, .refill_done
    );

endmodule

/* bench/clk_gen.sv */
module clk_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release just after a rising edge
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstn = 1'b1;
    end
endmodule

/* bench/icache_tb.sv */
`include "icache_defs.svh"

module icache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import icache_pkg::*;

    localparam int          NUM_TESTS       = 16;
    localparam int          SETS            = 1 << `ICACHE_INDEX_W;
    localparam int          IDX_LO          = `ICACHE_OFFSET_W + 2;
    localparam int          WATCHDOG_CYCLES = NUM_TESTS * 60;
    localparam logic [31:0] DATA_MASK       = 32'h5a5a0000;
    localparam logic [31:0] LINE_MASK       = ~((32'd1 << IDX_LO) - 32'd1);

    logic                      clk;
    logic                      rstn;
    logic                      req_valid;
    logic                      req_ready;
    cache_op_e                 req_op;
    logic [`ICACHE_ADDR_W-1:0] req_addr;
    logic                      resp_valid;
    logic                      resp_ready;
    logic [`ICACHE_WORD_W-1:0] resp_data;
    logic                      mem_req;
    logic [`ICACHE_ADDR_W-1:0] mem_addr;
    logic                      mem_addr_ok;
    logic                      mem_data_ok;
    logic [`ICACHE_WORD_W-1:0] mem_rdata;

    // stimulus table with the expected hit from the cache model
    cache_op_e   t_op    [NUM_TESTS];
    logic [31:0] t_addr  [NUM_TESTS];
    int          t_stall [NUM_TESTS];
    bit          t_hit   [NUM_TESTS];

    // cache model state
    logic [`ICACHE_TAG_W-1:0] m_tag   [2][SETS];
    bit                       m_valid [2][SETS];
    bit                       m_mru   [SETS];

    int          mem_reqs;
    logic [31:0] last_mem_addr;
    int          errors;
    int          tests_run;
    int          tests_failed;

    clk_gen #(.PERIOD(4), .RESET_CYCLES(2)) clk_gen0 (.clk, .rstn);

    icache_top dut0 (
        .clk, .rstn, .req_valid, .req_ready, .req_op, .req_addr,
        .resp_valid, .resp_ready, .resp_data,
        .mem_req, .mem_addr, .mem_addr_ok, .mem_data_ok, .mem_rdata
    );

    ////////////////////////////////////////
    // cache model
    ////////////////////////////////////////
    function automatic bit model_fetch(input logic [31:0] addr);
        logic [`ICACHE_INDEX_W-1:0] idx;
        logic [`ICACHE_TAG_W-1:0]   tag;
        bit                         way;
        bit                         hit;
        idx = addr[IDX_LO +: `ICACHE_INDEX_W];
        tag = addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        hit = 1'b1;
        if (m_valid[0][idx] && m_tag[0][idx] == tag) begin
            way = 1'b0;
        end else if (m_valid[1][idx] && m_tag[1][idx] == tag) begin
            way = 1'b1;
        end else begin
            hit = 1'b0;
            // empty way first, then the older one
            if (!m_valid[0][idx]) begin
                way = 1'b0;
            end else if (!m_valid[1][idx]) begin
                way = 1'b1;
            end else begin
                way = !m_mru[idx];
            end
            m_tag[way][idx]   = tag;
            m_valid[way][idx] = 1'b1;
        end
        m_mru[idx] = way;
        return hit;
    endfunction

    function automatic void model_invalidate();
        for (int s = 0; s < SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
        end
    endfunction

    task automatic set_entry(input int i, input cache_op_e op, input logic [31:0] addr,
                             input int stall);
        t_op[i]    = op;
        t_addr[i]  = addr;
        t_stall[i] = stall;
        if (op == op_fetch) begin
            t_hit[i] = model_fetch(addr);
        end else begin
            model_invalidate();
            t_hit[i] = 1'b0;
        end
    endtask

    task automatic load_table();
        model_invalidate();
        // one line and then hits inside it
        set_entry(0, op_fetch, 32'h0000_0030, 0);
        set_entry(1, op_fetch, 32'h0000_0034, 0);
        set_entry(2, op_fetch, 32'h0000_0038, 0);
        set_entry(3, op_fetch, 32'h0000_003c, 0);
        // three lines on set 3
        set_entry(4, op_fetch, 32'h0000_0130, 0);
        set_entry(5, op_fetch, 32'h0000_0034, 0);
        set_entry(6, op_fetch, 32'h0000_0230, 0);
        set_entry(7, op_fetch, 32'h0000_003c, 0);
        set_entry(8, op_fetch, 32'h0000_0138, int'($urandom_range(3, 0)));
        set_entry(9, op_fetch, 32'h0000_10a4, int'($urandom_range(3, 0)));
        set_entry(10, op_fetch, 32'h0000_10a8, int'($urandom_range(3, 0)));
        set_entry(11, op_inval_all, 32'h0000_0000, 0);
        // everything misses once after the flush
        set_entry(12, op_fetch, 32'h0000_003c, int'($urandom_range(3, 0)));
        set_entry(13, op_fetch, 32'h0000_10ac, int'($urandom_range(3, 0)));
        set_entry(14, op_fetch, 32'h0000_10a0, int'($urandom_range(3, 0)));
        set_entry(15, op_fetch, 32'h0000_0134, int'($urandom_range(3, 0)));
    endtask

    ////////////////////////////////////////
    // checks and reporting
    ////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %08h, expected %08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string label, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", label);
        end else begin
            tests_failed++;
            $display("%s: %0d mismatches", label, errors - errors_before);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    ////////////////////////////////////////
    // memory model
    ////////////////////////////////////////
    initial begin
        logic [31:0] line_base;
        mem_addr_ok   = 1'b0;
        mem_data_ok   = 1'b0;
        mem_rdata     = '0;
        mem_reqs      = 0;
        last_mem_addr = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rstn && mem_req) begin
                mem_reqs++;
                line_base     = mem_addr;
                last_mem_addr = mem_addr;
                wait_cycles(int'($urandom_range(3, 0)));
                mem_addr_ok = 1'b1;
                @(posedge clk);
                #1;
                mem_addr_ok = 1'b0;
                for (int beat = 0; beat < 4; beat++) begin
                    wait_cycles(int'($urandom_range(3, 0)));
                    mem_data_ok = 1'b1;
                    mem_rdata   = (line_base + 32'(beat * 4)) ^ DATA_MASK;
                    @(posedge clk);
                    #1;
                    mem_data_ok = 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////
    // request and response driving
    ////////////////////////////////////////
    task automatic drive_request(input int j);
        req_valid = 1'b1;
        req_op    = t_op[j];
        req_addr  = t_addr[j];
    endtask

    task automatic wait_accept();
        bit accepted;
        accepted = 1'b0;
        while (!accepted) begin
            #1;
            accepted = req_ready;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_fetch(input int i);
        int          cycles;
        int          first_cycle;
        int          stalls;
        bit          seen;
        bit          done;
        logic [31:0] exp_data;
        exp_data    = (t_addr[i] & ~32'h3) ^ DATA_MASK;
        cycles      = 0;
        first_cycle = 0;
        stalls      = 0;
        seen        = 1'b0;
        done        = 1'b0;
        while (!done) begin
            #1;
            cycles++;
            if (resp_valid) begin
                if (!seen) begin
                    seen        = 1'b1;
                    first_cycle = cycles;
                end
                check_value("resp_data", resp_data, exp_data);
                if (resp_ready) begin
                    done = 1'b1;
                    // completion edge also takes the next request
                    if (req_valid) begin
                        check_value("req_ready", 32'(req_ready), 32'h1);
                    end
                end else begin
                    stalls++;
                end
            end else if (seen) begin
                check_value("resp_valid", 32'(resp_valid), 32'h1);
            end
            @(posedge clk);
            #1;
            if (seen && stalls >= t_stall[i]) begin
                resp_ready = 1'b1;
            end
        end
        if (t_hit[i]) begin
            check_value("hit_latency", 32'(first_cycle), 32'h1);
        end
    endtask

    task automatic run_invalidate();
        bit done;
        done = 1'b0;
        while (!done) begin
            #1;
            check_value("resp_valid", 32'(resp_valid), 32'h0);
            done = req_ready;
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        int errors_before;
        int reqs_before;
        void'($urandom(32'h387e2fa3));
        req_valid    = 1'b0;
        req_op       = op_fetch;
        req_addr     = '0;
        resp_ready   = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        load_table();

        wait (rstn === 1'b1);
        #1;
        errors_before = errors;
        check_value("req_ready", 32'(req_ready), 32'h1);
        check_value("resp_valid", 32'(resp_valid), 32'h0);
        check_value("mem_req", 32'(mem_req), 32'h0);
        report_test("reset", errors_before);

        @(posedge clk);
        #1;
        drive_request(0);
        wait_accept();
        for (int i = 0; i < NUM_TESTS; i++) begin
            errors_before = errors;
            reqs_before   = mem_reqs;
            resp_ready    = (t_stall[i] == 0);
            if (i + 1 < NUM_TESTS) begin
                drive_request(i + 1);
            end else begin
                req_valid = 1'b0;
            end
            if (t_op[i] == op_fetch) begin
                run_fetch(i);
            end else begin
                run_invalidate();
            end
            check_value("mem_req_count", 32'(mem_reqs - reqs_before),
                        (t_op[i] == op_fetch && !t_hit[i]) ? 32'h1 : 32'h0);
            if (t_op[i] == op_fetch && !t_hit[i]) begin
                check_value("mem_addr", last_mem_addr, t_addr[i] & LINE_MASK);
            end
            report_test($sformatf("test %0d %s %08h %s", i, t_op[i].name(), t_addr[i],
                                  t_hit[i] ? "hit" : "miss"), errors_before);
        end

        $display("%0d tests run, %0d passed, %0d failed", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, only %0d tests finished", WATCHDOG_CYCLES,
                 tests_run);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* project.f */
+incdir+src
src/icache_pkg.sv
src/icache_array_if.sv
src/icache_req_buffer.sv
src/icache_storage.sv
src/icache_ctrl.sv
src/icache_mem_port.sv
src/icache_top.sv
bench/clk_gen.sv
bench/icache_tb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module icache_tb \
    -f project.f \
    -o icache_sim

out=$(./obj_dir/icache_sim)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
